/* hw/buf_cfg_pkg.sv */
package buf_cfg_pkg;

    // Data word width
    localparam int data_w = 32;

    // Chain geometry
    localparam int num_stages  = 8;
    localparam int stage_depth = 2;
    localparam int capacity    = num_stages * stage_depth;

    // Occupancy counter width
    localparam int count_w = 16;

    // Cycles for a lone word to reach the head of an empty chain
    localparam int fill_latency = num_stages;

endpackage

/* hw/buf_stat_pkg.sv */
package buf_stat_pkg;

    // Stage occupancy where the head register fills first
    typedef enum logic [1:0] {
        st_empty,
        st_one,
        st_two
    } stage_state_t;

    // Sticky flag levels
    localparam logic flag_set   = 1'b1;
    localparam logic flag_clear = 1'b0;

endpackage

/* hw/shift_stage.sv */
`timescale 1ns/1ps

module shift_stage
    import buf_cfg_pkg::*, buf_stat_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_vld,
    input  logic [data_w-1:0] in_data,
    output logic              full,
    input  logic              out_take,
    output logic [data_w-1:0] out_data,
    output logic              empty
);

    stage_state_t      state;
    stage_state_t      state_nxt;
    logic [data_w-1:0] head_q;
    logic [data_w-1:0] back_q;

    // ##############################
    // Occupancy FSM
    // ##############################

    always_comb begin
        state_nxt = state;
        case (state)
            st_empty: begin
                if (in_vld) state_nxt = st_one;
            end
            st_one: begin
                if (in_vld && !out_take) state_nxt = st_two;
                else if (!in_vld && out_take) state_nxt = st_empty;
            end
            st_two: begin
                if (out_take) state_nxt = st_one;
            end
            default: state_nxt = st_empty;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_empty;
        end else begin
            state <= state_nxt;
        end
    end

    // ##############################
    // Data registers
    // ##############################

    // Arrival goes to head when stage is empty or being emptied
    always_ff @(posedge clk) begin
        case (state)
            st_empty: begin
                if (in_vld) head_q <= in_data;
            end
            st_one: begin
                if (in_vld && out_take) head_q <= in_data;
                else if (in_vld) back_q <= in_data;
            end
            st_two: begin
                if (out_take) head_q <= back_q;
            end
            default: begin
            end
        endcase
    end

    assign full     = (state == st_two);
    assign empty    = (state == st_empty);
    assign out_data = head_q;

endmodule

/* hw/shift_chain.sv */
`timescale 1ns/1ps

module shift_chain
    import buf_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic [data_w-1:0] push_data,
    output logic              full,
    input  logic              pop,
    output logic [data_w-1:0] head_data,
    output logic              empty
);

    logic [num_stages-1:0] stage_full;
    logic [num_stages-1:0] stage_empty;
    logic [num_stages-1:0] stage_take;
    logic [num_stages-1:0] stage_in_vld;
    logic [data_w-1:0]     stage_in_data  [num_stages];
    logic [data_w-1:0]     stage_out_data [num_stages];

    assign stage_in_vld[0]  = push;
    assign stage_in_data[0] = push_data;

    for (genvar i = 0; i < num_stages; i++) begin : g_stage
        if (i < num_stages - 1) begin : g_fwd
            // Move on whenever holding a word and the next stage has room
            assign stage_take[i]      = !stage_empty[i] && !stage_full[i+1];
            assign stage_in_vld[i+1]  = stage_take[i];
            assign stage_in_data[i+1] = stage_out_data[i];
        end else begin : g_last
            assign stage_take[i] = pop;
        end

        shift_stage stage_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_vld   (stage_in_vld[i]),
            .in_data  (stage_in_data[i]),
            .full     (stage_full[i]),
            .out_take (stage_take[i]),
            .out_data (stage_out_data[i]),
            .empty    (stage_empty[i])
        );
    end

    assign full      = stage_full[0];
    assign empty     = stage_empty[num_stages-1];
    assign head_data = stage_out_data[num_stages-1];

endmodule

/* hw/write_guard.sv */
`timescale 1ns/1ps

module write_guard
    import buf_cfg_pkg::*, buf_stat_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [data_w-1:0] wr_data,
    input  logic              chain_full,
    input  logic              clear,
    output logic              push,
    output logic [data_w-1:0] push_data,
    output logic              overflow
);

    logic overflow_q;
    logic wr_drop;

    // Writes while the first stage is full are lost
    assign push      = wr_en && !chain_full;
    assign wr_drop   = wr_en && chain_full;
    assign push_data = wr_data;

    // ##############################
    // Sticky overflow
    // ##############################

    // New offence wins over clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow_q <= flag_clear;
        end else if (wr_drop) begin
            overflow_q <= flag_set;
        end else if (clear) begin
            overflow_q <= flag_clear;
        end
    end

    assign overflow = overflow_q;

endmodule

/* hw/read_tracker.sv */
`timescale 1ns/1ps

module read_tracker
    import buf_cfg_pkg::*, buf_stat_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd_en,
    input  logic               chain_empty,
    input  logic               push,
    input  logic               clear,
    output logic               pop,
    output logic [count_w-1:0] count,
    output logic               underflow
);

    logic [count_w-1:0] count_q;
    logic               underflow_q;
    logic               rd_miss;

    // Reads while empty are ignored
    assign pop     = rd_en && !chain_empty;
    assign rd_miss = rd_en && chain_empty;

    // ##############################
    // Occupancy count
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ##############################
    // Sticky underflow
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            underflow_q <= flag_clear;
        end else if (rd_miss) begin
            underflow_q <= flag_set;
        end else if (clear) begin
            underflow_q <= flag_clear;
        end
    end

    assign count     = count_q;
    assign underflow = underflow_q;

endmodule

/* hw/shift_buffer_top.sv */
`timescale 1ns/1ps

module shift_buffer_top
    import buf_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [data_w-1:0]  wr_data,
    input  logic               rd_en,
    input  logic               clear,
    output logic [data_w-1:0]  rd_data,
    output logic               empty,
    output logic               full,
    output logic [count_w-1:0] count,
    output logic               overflow,
    output logic               underflow
);

    logic              push;
    logic [data_w-1:0] push_data;
    logic              pop;

    // Input side
    write_guard write_guard_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .chain_full (full),
        .clear      (clear),
        .push       (push),
        .push_data  (push_data),
        .overflow   (overflow)
    );

    shift_chain shift_chain_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .head_data (rd_data),
        .empty     (empty)
    );

    // Output side
    read_tracker read_tracker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_en       (rd_en),
        .chain_empty (empty),
        .push        (push),
        .clear       (clear),
        .pop         (pop),
        .count       (count),
        .underflow   (underflow)
    );

endmodule

/* sim/shift_buffer_asserts.sv */
`timescale 1ns/1ps

module shift_buffer_asserts
    import buf_cfg_pkg::*, buf_stat_pkg::*;
(
    input logic               clk,
    input logic               rst_n,
    input logic               wr_en,
    input logic [data_w-1:0]  wr_data,
    input logic               rd_en,
    input logic               clear,
    input logic [data_w-1:0]  rd_data,
    input logic               empty,
    input logic               full,
    input logic [count_w-1:0] count,
    input logic               overflow,
    input logic               underflow
);

    logic [data_w-1:0]  ref_q [$];
    logic [data_w-1:0]  exp_head;
    logic [count_w-1:0] exp_count;
    logic               exp_ovf;
    logic               exp_udf;
    logic               acc_wr;
    logic               acc_rd;
    int unsigned        error_count = 0;

    // Transfers seen at the ports
    assign acc_wr = wr_en && !full;
    assign acc_rd = rd_en && !empty;

    // ##############################
    // Reference model
    // ##############################

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_q.delete();
            exp_head  <= '0;
            exp_count <= '0;
            exp_ovf   <= flag_clear;
            exp_udf   <= flag_clear;
        end else begin
            if (acc_rd && ref_q.size() > 0) begin
                void'(ref_q.pop_front());
            end
            if (acc_wr) begin
                ref_q.push_back(wr_data);
            end
            exp_head  <= (ref_q.size() > 0) ? ref_q[0] : '0;
            exp_count <= count_w'(ref_q.size());
            // An offence in the clear cycle keeps the flag
            if (wr_en && full) exp_ovf <= flag_set;
            else if (clear) exp_ovf <= flag_clear;
            if (rd_en && empty) exp_udf <= flag_set;
            else if (clear) exp_udf <= flag_clear;
        end
    end

    // ##############################
    // Port checks
    // ##############################

    a_count: assert property (@(posedge clk) disable iff (!rst_n) count == exp_count)
        else begin
            error_count++;
            $error("Mismatch at %0t: count got %0d expected %0d",
                   $time, $sampled(count), $sampled(exp_count));
        end

    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
                                acc_rd |-> rd_data == exp_head)
        else begin
            error_count++;
            $error("Mismatch at %0t: rd_data got %0h expected %0h",
                   $time, $sampled(rd_data), $sampled(exp_head));
        end

    a_overflow: assert property (@(posedge clk) disable iff (!rst_n) overflow == exp_ovf)
        else begin
            error_count++;
            $error("Mismatch at %0t: overflow got %0b expected %0b",
                   $time, $sampled(overflow), $sampled(exp_ovf));
        end

    a_underflow: assert property (@(posedge clk) disable iff (!rst_n) underflow == exp_udf)
        else begin
            error_count++;
            $error("Mismatch at %0t: underflow got %0b expected %0b",
                   $time, $sampled(underflow), $sampled(exp_udf));
        end

    // Full is certain at capacity
    a_full: assert property (@(posedge clk) disable iff (!rst_n)
                             exp_count == count_w'(capacity) |-> full)
        else begin
            error_count++;
            $error("Mismatch at %0t: full got %0b expected 1", $time, $sampled(full));
        end

endmodule

bind shift_buffer_top shift_buffer_asserts asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .clear     (clear),
    .rd_data   (rd_data),
    .empty     (empty),
    .full      (full),
    .count     (count),
    .overflow  (overflow),
    .underflow (underflow)
);

/* sim/shift_buffer_tb.sv */
`timescale 1ns/1ps

module shift_buffer_tb
    import buf_cfg_pkg::*;
();

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 10;
    localparam int random_cycles   = 2000;
    localparam int full_hold       = 20;
    localparam int extra_writes    = 8;
    localparam int drain_limit     = capacity * num_stages;
    localparam int watchdog_margin = 200;
    // Reset, latency probe, random run, fill, three drains, flag tests
    localparam int run_cycles = reset_cycles + 2 * fill_latency + random_cycles
                              + full_hold + extra_writes + 4 * drain_limit + 16;

    logic               clk;
    logic               rst_n;
    logic               wr_en;
    logic [data_w-1:0]  wr_data;
    logic               rd_en;
    logic               clear;
    logic [data_w-1:0]  rd_data;
    logic               empty;
    logic               full;
    logic [count_w-1:0] count;
    logic               overflow;
    logic               underflow;
    int unsigned        tb_errors = 0;
    int                 waited;
    int                 full_run;
    logic [data_w-1:0]  probe_word;

    shift_buffer_top shift_buffer_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .clear     (clear),
        .rd_data   (rd_data),
        .empty     (empty),
        .full      (full),
        .count     (count),
        .overflow  (overflow),
        .underflow (underflow)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            tb_errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Read until the buffer holds nothing
    task automatic drain();
        wr_en = 1'b0;
        rd_en = 1'b1;
        while (count != 0) step();
        rd_en = 1'b0;
    endtask

    task automatic finish_run();
        int unsigned checker_errors;
        checker_errors = shift_buffer_top_inst.asserts_inst.error_count;
        $display("Errors: checker %0d, testbench %0d, total %0d",
                 checker_errors, tb_errors, checker_errors + tb_errors);
        if (checker_errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Watchdog
    initial begin
        #((run_cycles + watchdog_margin) * clk_period);
        tb_errors++;
        $display("Timeout: run did not finish within %0d cycles",
                 run_cycles + watchdog_margin);
        finish_run();
    end

    initial begin
        void'($urandom(78));
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_data = '0;
        rd_en   = 1'b0;
        clear   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // ##############################
        // Reset state and latency
        // ##############################
        step();
        check_value("empty", empty, 1);
        check_value("full", full, 0);
        check_value("count", count, 0);
        check_value("overflow", overflow, 0);
        check_value("underflow", underflow, 0);

        probe_word = $urandom;
        wr_en      = 1'b1;
        wr_data    = probe_word;
        waited     = 0;
        do begin
            step();
            wr_en = 1'b0;
            waited++;
        end while (empty && waited < 2 * fill_latency);
        check_value("fill latency", waited, fill_latency);
        check_value("rd_data", rd_data, probe_word);
        drain();

        // ##############################
        // Random traffic
        // ##############################
        repeat (random_cycles) begin
            wr_en   = 1'($urandom % 2);
            rd_en   = 1'($urandom % 2);
            wr_data = $urandom;
            step();
        end
        drain();

        // Fill with no reads, then push into a full buffer
        wr_en    = 1'b1;
        full_run = 0;
        while (full_run < full_hold) begin
            wr_data = $urandom;
            step();
            full_run = full ? full_run + 1 : 0;
        end
        check_value("count", count, capacity);

        // Dropped write together with clear keeps overflow
        wr_data = $urandom;
        clear   = 1'b1;
        step();
        clear = 1'b0;
        check_value("overflow", overflow, 1);
        repeat (extra_writes) begin
            wr_data = $urandom;
            step();
        end
        check_value("count", count, capacity);
        check_value("overflow", overflow, 1);
        drain();

        // ##############################
        // Sticky flags
        // ##############################
        rd_en = 1'b1;
        step();
        rd_en = 1'b0;
        check_value("underflow", underflow, 1);
        check_value("count", count, 0);
        clear = 1'b1;
        step();
        clear = 1'b0;
        check_value("overflow", overflow, 0);
        check_value("underflow", underflow, 0);

        // Offence together with clear keeps the flag
        rd_en = 1'b1;
        clear = 1'b1;
        step();
        rd_en = 1'b0;
        clear = 1'b0;
        check_value("underflow", underflow, 1);
        clear = 1'b1;
        step();
        clear = 1'b0;
        check_value("underflow", underflow, 0);
        step();
        finish_run();
    end

endmodule

/* verilog.f */
hw/buf_cfg_pkg.sv
hw/buf_stat_pkg.sv
hw/shift_stage.sv
hw/shift_chain.sv
hw/write_guard.sv
hw/read_tracker.sv
hw/shift_buffer_top.sv
sim/shift_buffer_asserts.sv
sim/shift_buffer_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = shift_buffer_tb
FILELIST  = verilog.f
RUN_FLAGS = +verilator+error+limit+1000
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
